// ==== sim/chord_player_vectors.txt ====
# name root kind tones chord(root letter, root acc, kind a, kind b) tone0..tone3 (pitch 2, letter, acc)
# All hex but tones; glyph codes 0..b are A b C d E F g S blank dash o 7; unused tones are 0000
bad_root_c  c 0 0 8888 0000 0000 0000 0000
db_major    4 0 3 3188 0431 0858 0b01 0000
g_major     a 0 3 6888 0a68 0e18 1138 0000
a_minor     0 1 3 0898 0008 0328 0748 0000
fs_minor    9 1 3 5798 0957 0c08 1027 0000
c_aug       3 2 3 2808 0328 0748 0b67 0000
eb_aug      6 2 3 4108 0641 0a68 0e18 0000
b_dim       2 3 3 18a8 0218 0538 0858 0000
e_dim       7 3 3 48a8 0748 0a68 0d11 0000
bad_root_f  f 3 0 8888 0000 0000 0000 0000
b_dom7      2 4 4 183b 0218 0637 0957 0c08
ab_dom7     b 4 4 013b 0b01 0f28 1241 1561
c_dim7      3 5 4 28ab 0328 0641 0961 0c08
a_dim7      0 5 4 08ab 0008 0328 0641 0961
f_maj7      8 6 4 588b 0858 0c08 0f28 1348
d_maj7      5 6 4 388b 0538 0957 0c08 1027
g_min7      a 7 4 689b 0a68 0d11 1138 1458
bb_min7     1 7 4 119b 0111 0431 0858 0b01

// ==== files.f ====
common/chord_pkg.sv
chord_seq/chord_sequencer.sv
chord_seq/chord_spell.sv
logic/note_display.sv
logic/tone_gen.sv
logic/chord_player_top.sv
sim/chord_player_chk.sv
sim/chord_player_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the chord player testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module chord_player_tb -f files.f -o chord_player_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status, see build.log"
	exit 1
fi

./obj_dir/chord_player_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status, see sim.log"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1

// ==== sim/chord_player_tb.sv ====
// Run from the project root; vectors come from sim/chord_player_vectors.txt
// CLK_HZ is 1 MHz, so half periods span about 600 to 2300 cycles
`default_nettype none

module chord_player_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_HZ     = 1_000_000;
	localparam int          WAIT_LIMIT = 10_000;	// Above any half period
	localparam logic [23:0] BLANK      = 24'h888888;

	logic        clk;
	logic        reset;
	logic [3:0]  note_sw;
	logic [2:0]  kind_sw;
	logic        load_btn;
	logic        play_btn;
	logic [6:0]  hex_root_letter;
	logic [6:0]  hex_root_acc;
	logic [6:0]  hex_kind_a;
	logic [6:0]  hex_kind_b;
	logic [6:0]  hex_tone_letter;
	logic [6:0]  hex_tone_acc;
	logic        speaker;

	int          total_errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	string       test_name;
	logic [3:0]  v_root;
	logic [2:0]  v_kind;
	int          v_tones;
	logic [15:0] v_chord;	// Root letter, root acc, kind a, kind b
	logic [15:0] v_tone [4];	// Pitch byte, letter, acc

	chord_player_top #(.CLK_HZ(CLK_HZ)) i_chord_player_top (
		.clk(clk), .reset(reset), .note_sw(note_sw), .kind_sw(kind_sw),
		.load_btn(load_btn), .play_btn(play_btn),
		.hex_root_letter(hex_root_letter), .hex_root_acc(hex_root_acc),
		.hex_kind_a(hex_kind_a), .hex_kind_b(hex_kind_b),
		.hex_tone_letter(hex_tone_letter), .hex_tone_acc(hex_tone_acc),
		.speaker(speaker)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reference decoder, active low, bit 6 is segment g
	function automatic logic [6:0] seg_pattern(input logic [3:0] glyph);
		case (glyph)
			4'h0:    return 7'b000_1000;	// A
			4'h1:    return 7'b000_0011;	// b
			4'h2:    return 7'b100_0110;	// C
			4'h3:    return 7'b010_0001;	// d
			4'h4:    return 7'b000_0110;	// E
			4'h5:    return 7'b000_1110;	// F
			4'h6:    return 7'b001_0000;	// g
			4'h7:    return 7'b001_0010;	// S
			4'h8:    return 7'b111_1111;	// Blank
			4'h9:    return 7'b011_1111;	// Dash
			4'ha:    return 7'b001_1100;	// o
			default: return 7'b111_1000;	// 7
		endcase
	endfunction

	// Equal temperament from A3 at 220 Hz, rounded to whole hertz
	function automatic int half_period(input int pitch);
		real freq;
		freq = 220.0 * (2.0 ** (pitch / 12.0));
		return CLK_HZ / (2 * $rtoi(freq + 0.5));
	endfunction

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_problem(input string text);
		$display("test %s: %s", test_name, text);
		test_errors++;
	endtask

	task automatic close_test();
		tests_run++;
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else
		begin
			$display("test %s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// Held 4 cycles, released 4, then sampled away from the clock edge
	task automatic press_button(input logic is_load, input logic [3:0] root,
			input logic [2:0] kind);
		@(posedge clk);
		note_sw <= root;
		kind_sw <= kind;
		if (is_load)
			load_btn <= 1'b1;
		else
			play_btn <= 1'b1;
		repeat (4) @(posedge clk);
		load_btn <= 1'b0;
		play_btn <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_digits(input logic [23:0] glyphs);
		logic [41:0] actual;
		logic [6:0]  expected;
		actual = {hex_root_letter, hex_root_acc, hex_kind_a, hex_kind_b,
			hex_tone_letter, hex_tone_acc};
		for (int d = 5; d >= 0; d--)
		begin
			expected = seg_pattern(glyphs[4*d +: 4]);
			if (actual[7*d +: 7] !== expected)
				report_mismatch($sformatf("digit %0d", 5 - d), expected, actual[7*d +: 7]);
		end
	endtask

	// Gives -1 when speaker holds still for WAIT_LIMIT cycles
	task automatic count_to_toggle(output int cycles);
		logic start;
		start = speaker;
		cycles = 0;
		while (speaker === start && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (speaker === start)
			cycles = -1;
	endtask

	task automatic check_pitch(input int pitch);
		int first;
		int span;
		int expected;
		expected = half_period(pitch);
		count_to_toggle(first);
		count_to_toggle(span);
		if (first < 0 || span < 0)
			report_problem("speaker did not toggle while a tone played");
		else if (span < expected - 1 || span > expected + 1)
			report_mismatch("half period", expected, span);
	endtask

	task automatic expect_silence(input int cycles);
		int loud;
		loud = 0;
		repeat (cycles)
		begin
			@(negedge clk);
			if (speaker !== 1'b0)
				loud++;
		end
		if (loud != 0)
			report_problem("speaker was not held low");
	endtask

	task automatic run_vector();
		logic [23:0] shown;
		press_button(1'b1, v_root, v_kind);
		check_digits(BLANK);	// Root alone shows nothing
		press_button(1'b1, v_root, v_kind);
		check_digits({v_chord, 8'h88});	// Stays blank when the root was refused
		if (v_tones > 0)
		begin
			for (int i = 0; i < v_tones; i++)
			begin
				press_button(1'b0, v_root, v_kind);
				shown = {v_chord, v_tone[i][7:0]};
				check_digits(shown);
				if (i == 0)
				begin
					press_button(1'b1, ~v_root, ~v_kind);	// Load while playing
					check_digits(shown);
				end
				check_pitch(v_tone[i][15:8]);
			end
			press_button(1'b0, v_root, v_kind);
			check_digits(BLANK);
			expect_silence(3000);
			press_button(1'b0, v_root, v_kind);
			check_digits(BLANK);
			expect_silence(3000);
		end
	endtask

	initial
	begin
		int          fd;
		int          fields;
		string       line;
		logic [15:0] t0;
		logic [15:0] t1;
		logic [15:0] t2;
		logic [15:0] t3;

		total_errors = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		note_sw      = 4'd0;
		kind_sw      = 3'd0;
		load_btn     = 1'b0;
		play_btn     = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		test_name = "after_reset";
		check_digits(BLANK);
		expect_silence(5000);
		close_test();

		fd = $fopen("sim/chord_player_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("the vector file could not be opened");
			total_errors++;
		end
		else
		begin
			while ($fgets(line, fd) > 0)
			begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%s %h %h %d %h %h %h %h %h", test_name, v_root,
					v_kind, v_tones, v_chord, t0, t1, t2, t3);
				if (fields != 9)
					report_problem("vector line has the wrong number of fields");
				else
				begin
					v_tone[0] = t0;
					v_tone[1] = t1;
					v_tone[2] = t2;
					v_tone[3] = t3;
					run_vector();
				end
				close_test();
			end
			$fclose(fd);
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/chord_player_chk.sv ====
// Bound into chord_sequencer; observes only and drives nothing
`default_nettype none

module chord_player_chk (
	input  wire logic              clk,
	input  wire logic              reset,
	input  chord_pkg::chord_kind_t kind,
	input  wire logic              chord_loaded,
	input  wire logic [1:0]        tone_index,
	input  wire logic              tone_on
);

	timeunit 1ns;
	timeprecision 1ps;

	index_in_range: assert property (@(posedge clk) disable iff (reset)
		{1'b0, tone_index} < chord_pkg::CHORD_TONES[kind])
		else $error("tone_index %0d past the last tone of kind %0d", tone_index, kind);

	tone_needs_chord: assert property (@(posedge clk) disable iff (reset)
		tone_on |-> chord_loaded)
		else $error("tone_on high while no chord is loaded");

	quiet_after_reset: assert property (@(posedge clk) reset |=> !tone_on)
		else $error("tone_on high in the cycle after reset");

endmodule

bind chord_sequencer chord_player_chk i_chord_player_chk (
	.clk(clk), .reset(reset), .kind(kind), .chord_loaded(chord_loaded),
	.tone_index(tone_index), .tone_on(tone_on)
);

`default_nettype wire

// ==== logic/chord_player_top.sv ====
// Buttons must already be synchronous and debounced, active high
// Digit outputs are active low; speaker is a square wave while a tone plays
`default_nettype none

module chord_player_top #(
	parameter logic [31:0] CLK_HZ = 32'd50_000_000
) (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic [3:0] note_sw,
	input  wire logic [2:0] kind_sw,
	input  wire logic       load_btn,
	input  wire logic       play_btn,
	output logic [6:0]      hex_root_letter,
	output logic [6:0]      hex_root_acc,
	output logic [6:0]      hex_kind_a,
	output logic [6:0]      hex_kind_b,
	output logic [6:0]      hex_tone_letter,
	output logic [6:0]      hex_tone_acc,
	output logic            speaker
);

	chord_pkg::root_t       seq_root;
	chord_pkg::chord_kind_t seq_kind;
	logic                   seq_loaded;
	logic [1:0]             seq_tone_index;
	logic                   seq_tone_on;
	chord_pkg::pitch_t      tone_pitch;
	chord_pkg::letter_t     tone_letter;
	chord_pkg::accidental_t tone_acc;
	chord_pkg::letter_t     root_letter;
	chord_pkg::accidental_t root_acc;
	chord_pkg::chord_kind_t kind;
	logic                   chord_loaded;
	logic                   tone_on;

	chord_sequencer i_chord_sequencer (
		.clk(clk), .reset(reset), .note_sw(note_sw),
		.kind_sw(chord_pkg::chord_kind_t'(kind_sw)),
		.load_btn(load_btn), .play_btn(play_btn),
		.root(seq_root), .kind(seq_kind), .chord_loaded(seq_loaded),
		.tone_index(seq_tone_index), .tone_on(seq_tone_on)
	);

	chord_spell i_chord_spell (
		.root(seq_root), .kind(seq_kind), .chord_loaded(seq_loaded),
		.tone_index(seq_tone_index), .tone_on(seq_tone_on),
		.tone_pitch(tone_pitch), .tone_letter(tone_letter), .tone_acc(tone_acc),
		.root_letter(root_letter), .root_acc(root_acc),
		.kind_out(kind), .loaded_out(chord_loaded), .tone_on_out(tone_on)
	);

	note_display i_note_display (
		.clk(clk), .reset(reset),
		.root_letter(root_letter), .root_acc(root_acc),
		.kind(kind), .chord_loaded(chord_loaded),
		.tone_letter(tone_letter), .tone_acc(tone_acc), .tone_on(tone_on),
		.hex_root_letter(hex_root_letter), .hex_root_acc(hex_root_acc),
		.hex_kind_a(hex_kind_a), .hex_kind_b(hex_kind_b),
		.hex_tone_letter(hex_tone_letter), .hex_tone_acc(hex_tone_acc)
	);

	tone_gen #(.CLK_HZ(CLK_HZ)) i_tone_gen (
		.clk(clk), .reset(reset), .tone_pitch(tone_pitch),
		.tone_on(tone_on), .speaker(speaker)
	);

endmodule

`default_nettype wire

// ==== logic/tone_gen.sv ====
// Half periods are rounded down from CLK_HZ, so pitch is slightly sharp
// CLK_HZ must be at least 2 * 784 for every note to toggle
`default_nettype none

module tone_gen #(
	parameter logic [31:0] CLK_HZ = 32'd50_000_000
) (
	input  wire logic         clk,
	input  wire logic         reset,
	input  chord_pkg::pitch_t tone_pitch,
	input  wire logic         tone_on,
	output logic              speaker
);

	logic [31:0]       half_period [23];
	logic [31:0]       count;
	chord_pkg::pitch_t last_pitch;
	logic              tone_on_d;
	logic              restart;

	for (genvar i = 0; i < 23; i++)
	begin : g_half_period
		assign half_period[i] = CLK_HZ / (32'd2 * 32'(chord_pkg::NOTE_FREQ_HZ[i]));
	end

	assign restart = !tone_on_d || tone_pitch != last_pitch;	// New note or new pitch

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count      <= '0;
			speaker    <= 1'b0;
			tone_on_d  <= 1'b0;
			last_pitch <= '0;
		end
		else
		begin
			tone_on_d  <= tone_on;
			last_pitch <= tone_pitch;
			if (!tone_on || restart)
			begin
				count   <= '0;
				speaker <= 1'b0;
			end
			else if (count == half_period[tone_pitch] - 32'd1)
			begin
				count   <= '0;
				speaker <= !speaker;
			end
			else
				count <= count + 32'd1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/note_display.sv ====
// All six digit outputs are registered, one cycle behind the inputs
// Digits are active low and show blank out of reset
`default_nettype none

module note_display (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  chord_pkg::letter_t        root_letter,
	input  chord_pkg::accidental_t    root_acc,
	input  chord_pkg::chord_kind_t    kind,
	input  wire logic                 chord_loaded,
	input  chord_pkg::letter_t        tone_letter,
	input  chord_pkg::accidental_t    tone_acc,
	input  wire logic                 tone_on,
	output logic [6:0]                hex_root_letter,
	output logic [6:0]                hex_root_acc,
	output logic [6:0]                hex_kind_a,
	output logic [6:0]                hex_kind_b,
	output logic [6:0]                hex_tone_letter,
	output logic [6:0]                hex_tone_acc
);

	chord_pkg::glyph_t g_root_letter;
	chord_pkg::glyph_t g_root_acc;
	chord_pkg::glyph_t g_kind_a;
	chord_pkg::glyph_t g_kind_b;
	chord_pkg::glyph_t g_tone_letter;
	chord_pkg::glyph_t g_tone_acc;

	function automatic chord_pkg::glyph_t letter_glyph(input chord_pkg::letter_t letter);
		return chord_pkg::glyph_t'({1'b0, letter});	// Same code space
	endfunction

	function automatic chord_pkg::glyph_t acc_glyph(input chord_pkg::accidental_t acc);
		case (acc)
			chord_pkg::ACC_FLAT:  return chord_pkg::GLYPH_B;
			chord_pkg::ACC_SHARP: return chord_pkg::GLYPH_S;
			default:              return chord_pkg::GLYPH_BLANK;
		endcase
	endfunction

	always_comb
	begin
		g_root_letter = chord_pkg::GLYPH_BLANK;
		g_root_acc    = chord_pkg::GLYPH_BLANK;
		g_kind_a      = chord_pkg::GLYPH_BLANK;
		g_kind_b      = chord_pkg::GLYPH_BLANK;
		g_tone_letter = chord_pkg::GLYPH_BLANK;
		g_tone_acc    = chord_pkg::GLYPH_BLANK;
		if (chord_loaded)
		begin
			g_root_letter = letter_glyph(root_letter);
			g_root_acc    = acc_glyph(root_acc);
			g_kind_a      = chord_pkg::KIND_GLYPHS[kind][0];
			g_kind_b      = chord_pkg::KIND_GLYPHS[kind][1];
		end
		if (tone_on)
		begin
			g_tone_letter = letter_glyph(tone_letter);
			g_tone_acc    = acc_glyph(tone_acc);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hex_root_letter <= chord_pkg::SEG_PATTERN[chord_pkg::GLYPH_BLANK];
			hex_root_acc    <= chord_pkg::SEG_PATTERN[chord_pkg::GLYPH_BLANK];
			hex_kind_a      <= chord_pkg::SEG_PATTERN[chord_pkg::GLYPH_BLANK];
			hex_kind_b      <= chord_pkg::SEG_PATTERN[chord_pkg::GLYPH_BLANK];
			hex_tone_letter <= chord_pkg::SEG_PATTERN[chord_pkg::GLYPH_BLANK];
			hex_tone_acc    <= chord_pkg::SEG_PATTERN[chord_pkg::GLYPH_BLANK];
		end
		else
		begin
			hex_root_letter <= chord_pkg::SEG_PATTERN[g_root_letter];
			hex_root_acc    <= chord_pkg::SEG_PATTERN[g_root_acc];
			hex_kind_a      <= chord_pkg::SEG_PATTERN[g_kind_a];
			hex_kind_b      <= chord_pkg::SEG_PATTERN[g_kind_b];
			hex_tone_letter <= chord_pkg::SEG_PATTERN[g_tone_letter];
			hex_tone_acc    <= chord_pkg::SEG_PATTERN[g_tone_acc];
		end
	end

endmodule

`default_nettype wire

// ==== chord_seq/chord_spell.sv ====
// Purely combinational; expects root 0..11 as the sequencer guarantees
// Double accidentals are respelled from the root table
`default_nettype none

module chord_spell (
	input  chord_pkg::root_t          root,
	input  chord_pkg::chord_kind_t    kind,
	input  wire logic                 chord_loaded,
	input  wire logic [1:0]           tone_index,
	input  wire logic                 tone_on,
	output chord_pkg::pitch_t         tone_pitch,
	output chord_pkg::letter_t        tone_letter,
	output chord_pkg::accidental_t    tone_acc,
	output chord_pkg::letter_t        root_letter,
	output chord_pkg::accidental_t    root_acc,
	output chord_pkg::chord_kind_t    kind_out,
	output logic                      loaded_out,
	output logic                      tone_on_out
);

	logic [4:0]           interval;
	logic [3:0]           tone_pc;
	logic [3:0]           letter_sum;
	chord_pkg::letter_t   step_letter;
	logic [3:0]           natural_pc;
	logic [4:0]           pc_diff;
	chord_pkg::spelling_t root_sp;
	chord_pkg::spelling_t fallback_sp;

	assign interval   = chord_pkg::CHORD_INTERVALS[kind][tone_index];
	assign tone_pitch = {1'b0, root} + interval;
	assign tone_pc    = (tone_pitch >= 5'd12) ? 4'(tone_pitch - 5'd12) : tone_pitch[3:0];

	assign root_sp     = chord_pkg::ROOT_SPELLING[root];
	assign root_letter = root_sp.letter;
	assign root_acc    = root_sp.acc;

	// Chord tones sit on every other letter
	assign letter_sum  = {1'b0, root_sp.letter} + {1'b0, tone_index, 1'b0};
	assign step_letter = (letter_sum >= 4'd7) ? 3'(letter_sum - 4'd7) : letter_sum[2:0];
	assign natural_pc  = chord_pkg::LETTER_PITCH[step_letter];

	// Offset by 12 so that 11/12/13 mean flat/natural/sharp
	assign pc_diff     = {1'b0, tone_pc} + 5'd12 - {1'b0, natural_pc};
	assign fallback_sp = chord_pkg::ROOT_SPELLING[tone_pc];

	always_comb
	begin
		tone_letter = step_letter;
		case (pc_diff)
			5'd11:   tone_acc = chord_pkg::ACC_FLAT;
			5'd12:   tone_acc = chord_pkg::ACC_NATURAL;
			5'd13:   tone_acc = chord_pkg::ACC_SHARP;
			default:
			begin
				tone_letter = fallback_sp.letter;
				tone_acc    = fallback_sp.acc;
			end
		endcase
	end

	assign kind_out    = kind;
	assign loaded_out  = chord_loaded;
	assign tone_on_out = tone_on;

endmodule

`default_nettype wire

// ==== chord_seq/chord_sequencer.sv ====
// Buttons are level inputs, already synchronous to clk; a press is a rising edge
// Roots 12..15 are refused at entry
`default_nettype none

module chord_sequencer (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  chord_pkg::root_t          note_sw,
	input  chord_pkg::chord_kind_t    kind_sw,
	input  wire logic                 load_btn,
	input  wire logic                 play_btn,
	output chord_pkg::root_t          root,
	output chord_pkg::chord_kind_t    kind,
	output logic                      chord_loaded,
	output logic [1:0]                tone_index,
	output logic                      tone_on
);

	typedef enum logic [1:0] {ST_WAIT_ROOT, ST_WAIT_KIND, ST_LOADED, ST_PLAYING} state_t;

	state_t state;
	logic   load_prev;
	logic   play_prev;
	logic   load_press;
	logic   play_press;
	logic   last_tone;

	assign load_press = load_btn && !load_prev;
	assign play_press = play_btn && !play_prev;
	assign last_tone  = {1'b0, tone_index} == chord_pkg::CHORD_TONES[kind] - 3'd1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state        <= ST_WAIT_ROOT;
			load_prev    <= 1'b0;
			play_prev    <= 1'b0;
			root         <= '0;
			kind         <= chord_pkg::KIND_MAJOR;
			chord_loaded <= 1'b0;
			tone_index   <= 2'd0;
			tone_on      <= 1'b0;
		end
		else
		begin
			load_prev <= load_btn;
			play_prev <= play_btn;
			case (state)
				ST_WAIT_ROOT:
					if (load_press && note_sw < 4'd12)
					begin
						root  <= note_sw;
						state <= ST_WAIT_KIND;
					end
				ST_WAIT_KIND:
					if (load_press)
					begin
						kind         <= kind_sw;
						chord_loaded <= 1'b1;
						state        <= ST_LOADED;
					end
				ST_LOADED:
					if (play_press)
					begin
						tone_index <= 2'd0;	// Root tone first
						tone_on    <= 1'b1;
						state      <= ST_PLAYING;
					end
				default:
					if (play_press)
					begin
						if (last_tone)
						begin
							tone_index   <= 2'd0;
							tone_on      <= 1'b0;
							chord_loaded <= 1'b0;
							state        <= ST_WAIT_ROOT;
						end
						else
							tone_index <= tone_index + 2'd1;
					end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== common/chord_pkg.sv ====
// Pitches count semitones up from A3; pitch classes run A=0 to G#=11
// Segment patterns are active low, bit 6 is segment g
`default_nettype none

package chord_pkg;

	typedef logic [4:0] pitch_t;	// 0..22, A3 to G5
	typedef logic [3:0] root_t;	// 0..11 valid
	typedef logic [2:0] letter_t;	// A=0 .. G=6

	typedef enum logic [2:0] {
		KIND_MAJOR, KIND_MINOR, KIND_AUG, KIND_DIM,
		KIND_DOM7, KIND_DIM7, KIND_MAJ7, KIND_MIN7
	} chord_kind_t;

	typedef enum logic [1:0] {ACC_NATURAL, ACC_FLAT, ACC_SHARP} accidental_t;

	// Letter glyphs share their code with letter_t
	typedef enum logic [3:0] {
		GLYPH_A, GLYPH_B, GLYPH_C, GLYPH_D, GLYPH_E, GLYPH_F, GLYPH_G,
		GLYPH_S, GLYPH_BLANK, GLYPH_DASH, GLYPH_O, GLYPH_7
	} glyph_t;

	typedef struct packed {
		letter_t     letter;
		accidental_t acc;
	} spelling_t;

	localparam logic [4:0] CHORD_INTERVALS [8][4] = '{
		'{5'd0, 5'd4, 5'd7, 5'd0}, '{5'd0, 5'd3, 5'd7, 5'd0},
		'{5'd0, 5'd4, 5'd8, 5'd0}, '{5'd0, 5'd3, 5'd6, 5'd0},
		'{5'd0, 5'd4, 5'd7, 5'd10}, '{5'd0, 5'd3, 5'd6, 5'd9},
		'{5'd0, 5'd4, 5'd7, 5'd11}, '{5'd0, 5'd3, 5'd7, 5'd10}
	};

	localparam logic [2:0] CHORD_TONES [8] = '{3, 3, 3, 3, 4, 4, 4, 4};

	localparam spelling_t ROOT_SPELLING [12] = '{
		'{3'd0, ACC_NATURAL}, '{3'd1, ACC_FLAT}, '{3'd1, ACC_NATURAL},
		'{3'd2, ACC_NATURAL}, '{3'd3, ACC_FLAT}, '{3'd3, ACC_NATURAL},
		'{3'd4, ACC_FLAT}, '{3'd4, ACC_NATURAL}, '{3'd5, ACC_NATURAL},
		'{3'd5, ACC_SHARP}, '{3'd6, ACC_NATURAL}, '{3'd0, ACC_FLAT}
	};

	localparam logic [3:0] LETTER_PITCH [7] = '{0, 2, 3, 5, 7, 8, 10};

	localparam logic [9:0] NOTE_FREQ_HZ [23] = '{
		220, 233, 247, 262, 277, 294, 311, 330, 349, 370, 392, 415,
		440, 466, 494, 523, 554, 587, 622, 659, 698, 740, 784
	};

	localparam glyph_t KIND_GLYPHS [8][2] = '{
		'{GLYPH_BLANK, GLYPH_BLANK}, '{GLYPH_DASH, GLYPH_BLANK},
		'{GLYPH_A, GLYPH_BLANK}, '{GLYPH_O, GLYPH_BLANK},
		'{GLYPH_D, GLYPH_7}, '{GLYPH_O, GLYPH_7},
		'{GLYPH_BLANK, GLYPH_7}, '{GLYPH_DASH, GLYPH_7}
	};

	localparam logic [6:0] SEG_PATTERN [12] = '{
		7'b000_1000, 7'b000_0011, 7'b100_0110, 7'b010_0001,	// A b C d
		7'b000_0110, 7'b000_1110, 7'b001_0000, 7'b001_0010,	// E F g S
		7'b111_1111, 7'b011_1111, 7'b001_1100, 7'b111_1000	// blank - o 7
	};

endpackage

`default_nettype wire
